// File: sources.f
rv_isa_pkg.sv
rv_pipe_pkg.sv
pipe_stage_reg.sv
mem_access.sv
writeback_unit.sv
reg_file.sv
mem_wb_backend.sv
tb_clock_gen.sv
backend_properties.sv
tb_mem_wb_backend.sv

// File: tb_mem_wb_backend.sv
`timescale 1ns/1ps

module tb_mem_wb_backend;

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic      clk;
    logic      rst_n;
    ex_mem_t   ex_i;
    logic      ex_ready_o;
    dmem_req_t dmem_o;
    logic      dmem_req_o;
    logic      dmem_ack_i = 1'b0;
    xlen_t     dmem_rdata_i = '0;
    reg_addr_t rs1_addr_i;
    reg_addr_t rs2_addr_i;
    xlen_t     rs1_data_o;
    xlen_t     rs2_data_o;

    xlen_t       model_mem [64];
    logic [15:0] lfsr_state = 16'd66;
    int          errors = 0;
    int          assert_errs = 0;
    int          cycles = 0;
    logic        acc_flag;
    logic        armed;
    int          wait_cnt;

    tb_clock_gen #(.PERIOD(40.0), .RESET_CYCLES(10)) u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mem_wb_backend i_mem_wb_backend (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_i         (ex_i),
        .ex_ready_o   (ex_ready_o),
        .dmem_o       (dmem_o),
        .dmem_req_o   (dmem_req_o),
        .dmem_ack_i   (dmem_ack_i),
        .dmem_rdata_i (dmem_rdata_i),
        .rs1_addr_i   (rs1_addr_i),
        .rs2_addr_i   (rs2_addr_i),
        .rs1_data_o   (rs1_data_o),
        .rs2_data_o   (rs2_data_o)
    );

    // galois lfsr with taps 16 14 13 11
    function automatic logic next_random_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic xlen_t random_bits(input int n);
        xlen_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], next_random_bit()};
        end
        return v;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_flag <= 1'b0;
        end else begin
            acc_flag <= ex_i.valid && ex_ready_o; // accepted at this edge
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // four-phase memory that answers after 1 to 4 falling edges
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_ack_i   <= 1'b0;
            dmem_rdata_i <= '0;
            armed        = 1'b0;
            wait_cnt     = 0;
        end else if (dmem_ack_i) begin
            if (!dmem_req_o) begin
                dmem_ack_i <= 1'b0;
            end
        end else if (dmem_req_o) begin
            if (!armed) begin
                armed    = 1'b1;
                wait_cnt = int'(random_bits(2)) + 1;
            end else begin
                wait_cnt--;
            end
            if (armed && wait_cnt == 0) begin
                armed = 1'b0;
                if (dmem_o.we) begin
                    for (int b = 0; b < 8; b++) begin
                        if (dmem_o.wmask[b]) begin
                            model_mem[dmem_o.addr[8:3]][b*8 +: 8] = dmem_o.wdata[b*8 +: 8];
                        end
                    end
                end
                dmem_rdata_i <= model_mem[dmem_o.addr[8:3]];
                dmem_ack_i   <= 1'b1;
            end
        end
    end

    task automatic check_value(input string name, input xlen_t exp, input xlen_t got);
        if (exp !== got) begin
            errors++;
            $display("ERR %s exp %h got %h", name, exp, got);
        end
    endtask

    function automatic ex_mem_t make_op(input reg_addr_t rd, input xlen_t res, input xlen_t sdata,
                                        input logic ld, input logic st, input int size,
                                        input logic uns);
        ex_mem_t op;
        op = '0;
        op.valid         = 1'b1;
        op.alu_res       = res;
        op.store_data    = sdata;
        op.reg_wen       = !st;
        op.reg_waddr     = rd;
        op.is_load       = ld;
        op.is_store      = st;
        op.size          = mem_size_e'(size);
        op.load_unsigned = uns;
        return op;
    endfunction

    // drives at a falling edge and returns at the falling edge after acceptance
    task automatic issue(input ex_mem_t op);
        ex_i = op;
        do @(negedge clk); while (!acc_flag);
        ex_i.valid = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output xlen_t val);
        rs1_addr_i = addr;
        #1;
        val = rs1_data_o;
    endtask

    task automatic wait_mem_done();
        do begin
            @(negedge clk);
            #1;
        end while (!ex_ready_o);
        repeat (2) @(negedge clk); // through mem_wb into the register file
    endtask

    task automatic test_reset();
        xlen_t v;
        for (int r = 0; r < NUM_REGS; r++) begin
            read_reg(reg_addr_t'(r), v);
            check_value($sformatf("rs1_data_o x%0d", r), '0, v);
        end
        rs2_addr_i = 5'd31;
        #1;
        check_value("rs2_data_o x31", '0, rs2_data_o);
        check_value("dmem_req_o", '0, xlen_t'(dmem_req_o));
        check_value("ex_ready_o", 64'd1, xlen_t'(ex_ready_o));
        @(negedge clk);
    endtask

    task automatic test_alu();
        xlen_t v;
        issue(make_op(5'd5, 64'h0123_4567_89AB_CDEF, '0, 1'b0, 1'b0, 3, 1'b0));
        @(negedge clk);
        read_reg(5'd5, v);
        check_value("rs1_data_o x5 one edge", '0, v);
        @(negedge clk);
        read_reg(5'd5, v);
        check_value("rs1_data_o x5 two edges", 64'h0123_4567_89AB_CDEF, v);
        @(negedge clk);
        ex_i = make_op(5'd6, 64'h6666, '0, 1'b0, 1'b0, 3, 1'b0);
        @(negedge clk);
        ex_i = make_op(5'd7, 64'h7777, '0, 1'b0, 1'b0, 3, 1'b0);
        @(negedge clk);
        ex_i.valid = 1'b0;
        @(negedge clk);
        read_reg(5'd6, v);
        check_value("rs1_data_o x6", 64'h6666, v);
        read_reg(5'd7, v);
        check_value("rs1_data_o x7 early", '0, v);
        @(negedge clk);
        read_reg(5'd7, v);
        check_value("rs1_data_o x7", 64'h7777, v);
        rs2_addr_i = 5'd6; // second port on another entry than rs1
        #1;
        check_value("rs2_data_o x6", 64'h6666, rs2_data_o);
        issue(make_op(5'd0, 64'hDEAD, '0, 1'b0, 1'b0, 3, 1'b0));
        repeat (3) @(negedge clk);
        read_reg(5'd0, v);
        check_value("rs1_data_o x0", '0, v);
        @(negedge clk);
    endtask

    task automatic test_stores();
        xlen_t exp;
        xlen_t data;
        int    idx;
        idx = 0;
        for (int size = 0; size < 4; size++) begin
            for (int off = 0; off < 8; off += (1 << size)) begin
                data = random_bits(64);
                exp  = model_mem[idx];
                for (int b = 0; b < (1 << size); b++) begin
                    exp[(off+b)*8 +: 8] = data[b*8 +: 8];
                end
                issue(make_op(5'd0, xlen_t'(idx*8 + off), data, 1'b0, 1'b1, size, 1'b0));
                wait_mem_done();
                check_value($sformatf("model_mem[%0d] size %0d off %0d", idx, size, off),
                            exp, model_mem[idx]);
                idx++;
            end
        end
    endtask

    function automatic xlen_t expected_load(input xlen_t dword, input int off, input int size,
                                            input logic uns);
        xlen_t lane;
        xlen_t keep;
        int    bits;
        lane = dword >> (off * 8);
        bits = 8 << size;
        if (bits == 64) begin
            return lane;
        end
        keep = (64'd1 << bits) - 1;
        lane = lane & keep;
        if (!uns && lane[bits-1]) begin
            lane = lane | ~keep; // sign fill
        end
        return lane;
    endfunction

    task automatic test_loads();
        xlen_t v;
        int    idx;
        int    rd;
        idx = 20;
        rd  = 8;
        for (int size = 0; size < 4; size++) begin
            for (int off = 0; off < 8; off += (1 << size)) begin
                for (int uns = 0; uns < 2; uns++) begin
                    issue(make_op(reg_addr_t'(rd), xlen_t'(idx*8 + off), '0, 1'b1, 1'b0, size,
                                  uns[0]));
                    wait_mem_done();
                    read_reg(reg_addr_t'(rd), v);
                    check_value($sformatf("rs1_data_o x%0d load size %0d off %0d u %0d",
                                          rd, size, off, uns),
                                expected_load(model_mem[idx], off, size, uns[0]), v);
                    idx = (idx == 63) ? 20 : idx + 1;
                    rd  = (rd == 20) ? 8 : rd + 1;
                end
            end
        end
    endtask

    task automatic test_backpressure();
        xlen_t v;
        int    low_seen;
        low_seen = 0;
        issue(make_op(5'd21, xlen_t'(40*8 + 4), '0, 1'b1, 1'b0, 2, 1'b0));
        ex_i = make_op(5'd22, 64'h2222_0000_0000_1111, '0, 1'b0, 1'b0, 3, 1'b0);
        forever begin
            @(negedge clk);
            if (acc_flag) begin
                break;
            end
            #1;
            if (!ex_ready_o) begin
                low_seen++;
            end
        end
        ex_i.valid = 1'b0;
        if (low_seen == 0) begin
            errors++;
            $display("ex_ready_o never went low while the load was pending");
        end
        @(negedge clk);
        read_reg(5'd21, v);
        check_value("rs1_data_o x21", expected_load(model_mem[40], 4, 2, 1'b0), v);
        read_reg(5'd22, v);
        check_value("rs1_data_o x22 early", '0, v);
        @(negedge clk);
        read_reg(5'd22, v);
        check_value("rs1_data_o x22", 64'h2222_0000_0000_1111, v);
    endtask

    initial begin
        ex_i       = '0;
        rs1_addr_i = '0;
        rs2_addr_i = '0;
        for (int i = 0; i < 64; i++) begin
            model_mem[i] = {32'(i) * 32'h9E37_79B1, ~32'(i) ^ 32'h5A5A_0000};
        end
        @(posedge rst_n);
        @(negedge clk);
        test_reset();
        test_alu();
        test_stores();
        test_loads();
        test_backpressure();
        repeat (2) @(negedge clk);
        assert_errs = i_mem_wb_backend.u_mem_access.u_handshake_props.assert_fails
                    + i_mem_wb_backend.u_reg_file.u_write_props.assert_fails;
        $display("errors: %0d from checks, %0d from assertions", errors, assert_errs);
        if (errors == 0 && assert_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: backend_properties.sv
`timescale 1ns/1ps

module backend_properties (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   req_i,
    input logic                   ack_i,
    input rv_pipe_pkg::dmem_req_t dmem_i,
    input logic                   wen_i,
    input rv_isa_pkg::reg_addr_t  waddr_i
);

    int assert_fails = 0; // read by the testbench at the end of the run

    // req stays up until memory answers
    req_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        req_i && !ack_i |=> req_i)
        else begin
            assert_fails++;
            $error("dmem req dropped before ack");
        end

    // request fields frozen from req rise until ack falls
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (req_i || ack_i) |=> (!(req_i || ack_i) || $stable(dmem_i)))
        else begin
            assert_fails++;
            $error("dmem request changed during handshake");
        end

    no_rise_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req_i) |-> !ack_i)
        else begin
            assert_fails++;
            $error("dmem req rose while ack still high");
        end

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wen_i |-> waddr_i != '0)
        else begin
            assert_fails++;
            $error("register file write to x0");
        end

endmodule

bind mem_access backend_properties u_handshake_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (dmem_req_o),
    .ack_i   (dmem_ack_i),
    .dmem_i  (dmem_o),
    .wen_i   (1'b0),
    .waddr_i (5'd0)
);

bind reg_file backend_properties u_write_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (1'b0),
    .ack_i   (1'b0),
    .dmem_i  ('0),
    .wen_i   (wen_i),
    .waddr_i (waddr_i)
);

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter realtime PERIOD       = 40.0,
    parameter int      RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: mem_wb_backend.sv
`timescale 1ns/1ps

module mem_wb_backend (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_pipe_pkg::ex_mem_t   ex_i,
    output logic                   ex_ready_o,
    output rv_pipe_pkg::dmem_req_t dmem_o,
    output logic                   dmem_req_o,
    input  logic                   dmem_ack_i,
    input  rv_isa_pkg::xlen_t      dmem_rdata_i,
    input  rv_isa_pkg::reg_addr_t  rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t  rs2_addr_i,
    output rv_isa_pkg::xlen_t      rs1_data_o,
    output rv_isa_pkg::xlen_t      rs2_data_o
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    ex_mem_t   ex_mem_q;
    mem_wb_t   mem_wb_d;
    mem_wb_t   mem_wb_q;
    logic      mem_hold;
    logic      rf_wen;
    reg_addr_t rf_waddr;
    xlen_t     rf_wdata;

    assign ex_ready_o = !mem_hold; // execute stalls while memory is busy

    pipe_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold_i (mem_hold),
        .d_i    (ex_i),
        .q_o    (ex_mem_q)
    );

    mem_access u_mem_access (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_i         (ex_mem_q),
        .wb_o         (mem_wb_d),
        .hold_o       (mem_hold),
        .dmem_o       (dmem_o),
        .dmem_req_o   (dmem_req_o),
        .dmem_ack_i   (dmem_ack_i),
        .dmem_rdata_i (dmem_rdata_i)
    );

    // never held, takes a bubble from mem_access instead
    pipe_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold_i (1'b0),
        .d_i    (mem_wb_d),
        .q_o    (mem_wb_q)
    );

    writeback_unit u_writeback_unit (
        .wb_i    (mem_wb_q),
        .wen_o   (rf_wen),
        .waddr_o (rf_waddr),
        .wdata_o (rf_wdata)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wen_i    (rf_wen),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr1_i (rs1_addr_i),
        .raddr2_i (rs2_addr_i),
        .rdata1_o (rs1_data_o),
        .rdata2_o (rs2_data_o)
    );

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wen_i,
    input  rv_isa_pkg::reg_addr_t waddr_i,
    input  rv_isa_pkg::xlen_t     wdata_i,
    input  rv_isa_pkg::reg_addr_t raddr1_i,
    input  rv_isa_pkg::reg_addr_t raddr2_i,
    output rv_isa_pkg::xlen_t     rdata1_o,
    output rv_isa_pkg::xlen_t     rdata2_o
);

    import rv_isa_pkg::*;

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin // entry 0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // asynchronous read, no bypass of the write in the same cycle
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit (
    input  rv_pipe_pkg::mem_wb_t  wb_i,
    output logic                  wen_o,
    output rv_isa_pkg::reg_addr_t waddr_o,
    output rv_isa_pkg::xlen_t     wdata_o
);

    import rv_isa_pkg::*;

    xlen_t shifted;
    xlen_t load_val;
    logic  sign;

    always_comb begin
        shifted = wb_i.load_data >> {wb_i.byte_off, 3'b000}; // lane down to bit 0
        case (wb_i.size)
            SIZE_B: begin
                sign     = !wb_i.load_unsigned && shifted[7];
                load_val = {{56{sign}}, shifted[7:0]};
            end
            SIZE_H: begin
                sign     = !wb_i.load_unsigned && shifted[15];
                load_val = {{48{sign}}, shifted[15:0]};
            end
            SIZE_W: begin
                sign     = !wb_i.load_unsigned && shifted[31];
                load_val = {{32{sign}}, shifted[31:0]};
            end
            default: begin
                sign     = 1'b0; // full width, nothing to extend
                load_val = shifted;
            end
        endcase
    end

    assign wdata_o = wb_i.is_load ? load_val : wb_i.alu_res;
    assign waddr_o = wb_i.reg_waddr;

    // x0 writes are dropped here
    assign wen_o = wb_i.valid && wb_i.reg_wen && (wb_i.reg_waddr != '0);

endmodule

// File: mem_access.sv
`timescale 1ns/1ps

module mem_access (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_pipe_pkg::ex_mem_t   ex_i,
    output rv_pipe_pkg::mem_wb_t   wb_o,
    output logic                   hold_o,
    output rv_pipe_pkg::dmem_req_t dmem_o,
    output logic                   dmem_req_o,
    input  logic                   dmem_ack_i,
    input  rv_isa_pkg::xlen_t      dmem_rdata_i
);

    import rv_isa_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_HI, // req high, waiting for ack
        ST_WAIT_LO  // req dropped, waiting for ack to fall
    } state_e;

    state_e     state_q;
    state_e     state_d;
    xlen_t      rdata_q;
    logic       mem_op;
    logic       done;
    logic [2:0] byte_off;
    logic [7:0] size_mask;

    assign mem_op   = ex_i.valid && (ex_i.is_load || ex_i.is_store);
    assign byte_off = ex_i.alu_res[2:0];
    assign done     = (state_q == ST_WAIT_LO) && !dmem_ack_i; // handshake closed

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (mem_op) begin
                    state_d = ST_WAIT_HI;
                end
            end
            ST_WAIT_HI: begin
                if (dmem_ack_i) begin
                    state_d = ST_WAIT_LO;
                end
            end
            ST_WAIT_LO: begin
                if (!dmem_ack_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // rdata is only valid while ack is high
    always_ff @(posedge clk) begin
        if (state_q == ST_WAIT_HI && dmem_ack_i) begin
            rdata_q <= dmem_rdata_i;
        end
    end

    always_comb begin
        case (ex_i.size)
            SIZE_B:  size_mask = 8'b0000_0001;
            SIZE_H:  size_mask = 8'b0000_0011;
            SIZE_W:  size_mask = 8'b0000_1111;
            default: size_mask = 8'b1111_1111;
        endcase
    end

    // ex_mem is frozen during the transaction, so the request stays put
    assign dmem_o.addr  = {ex_i.alu_res[63:3], 3'b000};
    assign dmem_o.wdata = ex_i.store_data << {byte_off, 3'b000};
    assign dmem_o.wmask = size_mask << byte_off;
    assign dmem_o.we    = ex_i.is_store;
    assign dmem_req_o   = (state_q == ST_WAIT_HI);

    assign hold_o = mem_op && !done;

    always_comb begin
        wb_o.valid         = ex_i.valid && (!mem_op || done); // bubble while busy
        wb_o.reg_wen       = ex_i.reg_wen;
        wb_o.reg_waddr     = ex_i.reg_waddr;
        wb_o.alu_res       = ex_i.alu_res;
        wb_o.load_data     = rdata_q;
        wb_o.is_load       = ex_i.is_load;
        wb_o.size          = ex_i.size;
        wb_o.load_unsigned = ex_i.load_unsigned;
        wb_o.byte_off      = byte_off;
    end

endmodule

// File: pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t stage_q;

    // valid bit sits inside the payload, so clearing it makes a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q <= '0;
        end else if (!hold_i) begin
            stage_q <= d_i;
        end
    end

    assign q_o = stage_q;

endmodule

// File: rv_pipe_pkg.sv
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // executed instruction handed over by the execute stage
    typedef struct packed {
        logic      valid;
        xlen_t     alu_res;       // address for loads and stores
        xlen_t     store_data;
        logic      reg_wen;
        reg_addr_t reg_waddr;
        logic      is_load;
        logic      is_store;
        mem_size_e size;
        logic      load_unsigned;
    } ex_mem_t;

    // contents of the MEM/WB register
    typedef struct packed {
        logic      valid;
        logic      reg_wen;
        reg_addr_t reg_waddr;
        xlen_t     alu_res;
        xlen_t     load_data;     // raw double word from memory
        logic      is_load;
        mem_size_e size;
        logic      load_unsigned;
        logic [2:0] byte_off;     // lane of the access inside the double word
    } mem_wb_t;

    // data memory request, held stable for the whole handshake
    typedef struct packed {
        xlen_t      addr;         // double word aligned
        xlen_t      wdata;
        logic [7:0] wmask;
        logic       we;
    } dmem_req_t;

endpackage

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN     = 64;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    // one integer data word
    typedef logic [XLEN-1:0] xlen_t;

    typedef logic [REG_AW-1:0] reg_addr_t; // x0..x31

    // access size, same order as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_B = 2'b00, // byte
        SIZE_H = 2'b01, // half word
        SIZE_W = 2'b10, // word
        SIZE_D = 2'b11  // double word
    } mem_size_e;

endpackage
